// ==== design/usb_out_defines.svh ====
/*
 * Sizes for the OUT protocol engine, fixed for one build configuration
 * Endpoint count and packet size also set the mask, index and offset widths
 */

`ifndef USB_OUT_DEFINES_SVH
`define USB_OUT_DEFINES_SVH

// Implemented OUT endpoints, numbers at or above this are ignored
`define USB_OUT_NUM_EPS 4

// Largest data payload in bytes, sets the put offset width
`define USB_OUT_MAX_PKT_BYTES 32

// Wait for the data packet after a token
// 17 bit times at 4 clocks per full-speed bit
`define USB_OUT_ACK_TIMEOUT 68

`endif

// ==== design/usb_pid_pkg.sv ====
/*
 * USB packet identifiers and the receive-side packet fields
 * Only the PIDs used by an OUT/SETUP endpoint are named
 */

package usb_pid_pkg;

  // Low nibble of the PID byte, check nibble already stripped
  typedef enum logic [3:0] {
    UsbPidOut   = 4'b0001,
    UsbPidSetup = 4'b1101,
    UsbPidData0 = 4'b0011,
    UsbPidData1 = 4'b1011,
    UsbPidAck   = 4'b0010,
    UsbPidNak   = 4'b1010,
    UsbPidStall = 4'b1110
  } usb_pid_e;

  // Packet class sits in the two low PID bits
  typedef enum logic [1:0] {
    UsbPidTypeSpecial   = 2'b00,
    UsbPidTypeToken     = 2'b01,
    UsbPidTypeHandshake = 2'b10,
    UsbPidTypeData      = 2'b11
  } usb_pid_type_e;

  // Field view of a PID, bit 3 is the DATA0/DATA1 toggle
  typedef struct packed {
    logic          toggle;
    logic          rsvd;
    usb_pid_type_e pid_type;
  } usb_pid_fields_t;

  // Same PID word seen as a whole code or as its fields
  typedef union packed {
    usb_pid_e        pid;
    usb_pid_fields_t fields;
  } usb_pid_u;

  // Packet framing strobes and the fields of the last packet
  typedef struct packed {
    logic       pkt_start;
    logic       pkt_end;
    logic       pkt_valid;
    usb_pid_u   pid;
    logic [6:0] addr;
    logic [3:0] endp;
  } rx_pkt_t;

  // One received payload byte
  typedef struct packed {
    logic       put;
    logic [7:0] data;
  } rx_byte_t;

endpackage

// ==== design/out_ep_pkg.sv ====
/*
 * Endpoint-side types of the OUT engine
 * Widths follow the endpoint count and packet size macros
 */

`include "usb_out_defines.svh"

package out_ep_pkg;

  // One bit per implemented endpoint
  typedef logic [`USB_OUT_NUM_EPS-1:0] ep_mask_t;
  typedef logic [$clog2(`USB_OUT_NUM_EPS)-1:0] ep_idx_t;
  typedef logic [$clog2(`USB_OUT_MAX_PKT_BYTES)-1:0] ep_offset_t;

  // Endpoint configuration from the register side
  typedef struct packed {
    ep_mask_t enabled;
    ep_mask_t control;
    ep_mask_t full;
    ep_mask_t stall;
  } ep_cfg_t;

  // Software write of selected toggle bits
  typedef struct packed {
    logic     we;
    ep_mask_t status;
    ep_mask_t mask;
  } tog_wr_t;

  // Byte handed to the endpoint buffer
  typedef struct packed {
    logic       put;
    ep_offset_t offset;
    logic [7:0] data;
  } ep_put_t;

  // Decoded packet end, valid only in the cycle of the end strobe
  typedef struct packed {
    logic    out_tok;
    logic    setup_tok;
    logic    data_ok;
    logic    data_bad;
    logic    ep_active;
    logic    ep_control;
    ep_idx_t ep;
    logic    toggle;
  } rx_evt_t;

  typedef enum logic [1:0] {
    XactIdle,
    XactWaitData,
    XactInData,
    XactDataEnd
  } xact_state_e;

endpackage

// ==== design/usb_out_token_decode.sv ====
/*
 * Combinational decode of each received packet end
 * Endpoint numbers beyond the implemented range map to index 0, inactive
 */

`include "usb_out_defines.svh"

module usb_out_token_decode (
  input  usb_pid_pkg::rx_pkt_t  rx_pkt_i,
  input  logic [6:0]            dev_addr_i,
  input  out_ep_pkg::ep_cfg_t   ep_cfg_i,
  output out_ep_pkg::rx_evt_t   rx_evt_o
);

  usb_pid_pkg::usb_pid_u pid;
  out_ep_pkg::ep_idx_t   ep_idx;
  logic                  pkt_ok;
  logic                  is_token;
  logic                  is_data;
  logic                  ep_in_hw;

  assign pid = rx_pkt_i.pid;

  // Packet end with good CRC and PID check
  assign pkt_ok = rx_pkt_i.pkt_end && rx_pkt_i.pkt_valid;

  // Token for this device, kind decided below
  assign is_token = pkt_ok &&
                    (pid.fields.pid_type == usb_pid_pkg::UsbPidTypeToken) &&
                    (rx_pkt_i.addr == dev_addr_i);

  // Only DATA0 and DATA1 carry OUT payload
  assign is_data = (pid.pid == usb_pid_pkg::UsbPidData0) ||
                   (pid.pid == usb_pid_pkg::UsbPidData1);

  ////////////////////////////////////////
  // Endpoint resolution
  ////////////////////////////////////////

  // Extra top bit keeps the compare right at 16 endpoints
  assign ep_in_hw = {1'b0, rx_pkt_i.endp} < 5'(`USB_OUT_NUM_EPS);

  // Fold to 0 so the masks are never indexed out of range
  assign ep_idx = ep_in_hw ? rx_pkt_i.endp[$bits(out_ep_pkg::ep_idx_t)-1:0] : '0;

  assign rx_evt_o.out_tok    = is_token && (pid.pid == usb_pid_pkg::UsbPidOut);
  assign rx_evt_o.setup_tok  = is_token && (pid.pid == usb_pid_pkg::UsbPidSetup);
  assign rx_evt_o.data_ok    = pkt_ok && is_data;
  // Corrupt packet or a valid packet of any other kind
  assign rx_evt_o.data_bad   = rx_pkt_i.pkt_end && (!rx_pkt_i.pkt_valid || !is_data);
  assign rx_evt_o.ep_active  = ep_in_hw && ep_cfg_i.enabled[ep_idx];
  assign rx_evt_o.ep_control = ep_cfg_i.control[ep_idx];
  assign rx_evt_o.ep         = ep_idx;
  // Meaningful only together with data_ok
  assign rx_evt_o.toggle     = pid.fields.toggle;

endmodule

// ==== design/usb_out_data_toggle.sv ====
/*
 * Per-endpoint DATA0/DATA1 toggle state with software override
 * A software write in the same cycle wins over hardware updates
 */

module usb_out_data_toggle (
  input  logic                 clk_48mhz_i,
  input  logic                 rst_ni,
  input  logic                 link_reset_i,
  input  out_ep_pkg::rx_evt_t  rx_evt_i,
  input  logic                 flip_i,
  input  out_ep_pkg::ep_idx_t  cur_ep_i,
  input  out_ep_pkg::tog_wr_t  tog_wr_i,
  output out_ep_pkg::ep_mask_t toggle_o,
  output logic                 bad_toggle_o
);

  out_ep_pkg::ep_mask_t toggle_q;
  out_ep_pkg::ep_mask_t toggle_d;

  always_comb begin
    toggle_d = toggle_q;
    // SETUP always restarts the sequence at DATA0
    if (rx_evt_i.setup_tok && rx_evt_i.ep_active) begin
      toggle_d[rx_evt_i.ep] = 1'b0;
    end else if (flip_i) begin
      toggle_d[cur_ep_i] = ~toggle_q[cur_ep_i];
    end
    // Masked replace from software
    if (tog_wr_i.we) begin
      toggle_d = (toggle_d & ~tog_wr_i.mask) | (tog_wr_i.status & tog_wr_i.mask);
    end
  end

  always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      toggle_q <= '0;
    end else if (link_reset_i) begin
      toggle_q <= '0;
    end else begin
      toggle_q <= toggle_d;
    end
  end

  assign toggle_o = toggle_q;

  // Host resent a packet whose ACK it missed
  // Data packets carry no endpoint, the token's endpoint is the current one
  assign bad_toggle_o = rx_evt_i.data_ok && (rx_evt_i.toggle != toggle_q[cur_ep_i]);

endmodule

// ==== design/usb_out_data_path.sv ====
/*
 * Turns received bytes into endpoint puts, one cycle behind the rx strobe
 * Bytes beyond the maximum packet size overwrite the last offset
 */

module usb_out_data_path (
  input  logic                    clk_48mhz_i,
  input  logic                    rst_ni,
  input  usb_pid_pkg::rx_byte_t   rx_byte_i,
  input  out_ep_pkg::xact_state_e state_i,
  input  out_ep_pkg::ep_idx_t     cur_ep_i,
  input  out_ep_pkg::ep_mask_t    full_i,
  output out_ep_pkg::ep_put_t     put_o,
  output logic                    store_fail_o
);

  logic                   put_q;
  out_ep_pkg::ep_offset_t offset_q;
  logic [7:0]             data_q;
  logic                   fail_q;
  logic                   offset_inc;

  // Byte is held until the next strobe
  always_ff @(posedge clk_48mhz_i) begin
    if (rx_byte_i.put) begin
      data_q <= rx_byte_i.data;
    end
  end

  // Puts only while the data packet of a transaction is open
  always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      put_q <= 1'b0;
    end else begin
      put_q <= (state_i == out_ep_pkg::XactInData) && rx_byte_i.put;
    end
  end

  ////////////////////////////////////////
  // Offset and store failure
  ////////////////////////////////////////

  // Stop counting once the packet will be NAKed or the offset is at max
  assign offset_inc = put_q && !fail_q && !(&offset_q);

  always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      offset_q <= '0;
    end else if (state_i == out_ep_pkg::XactWaitData) begin
      offset_q <= '0;
    end else if ((state_i == out_ep_pkg::XactInData) && offset_inc) begin
      offset_q <= offset_q + 1'b1;
    end
  end

  // Sticky within a transaction, the endpoint may free space too late
  always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fail_q <= 1'b0;
    end else if ((state_i == out_ep_pkg::XactIdle) ||
                 (state_i == out_ep_pkg::XactWaitData)) begin
      fail_q <= 1'b0;
    end else if (put_q && full_i[cur_ep_i]) begin
      fail_q <= 1'b1;
    end
  end

  assign put_o = '{put: put_q, offset: offset_q, data: data_q};

  // Also covers a zero-length packet to a full endpoint
  assign store_fail_o = fail_q || full_i[cur_ep_i];

endmodule

// ==== design/usb_out_xact_fsm.sv ====
/*
 * OUT and SETUP transaction sequencing and handshake choice
 * Strobes are combinational from state and inputs, one cycle wide
 */

`include "usb_out_defines.svh"

module usb_out_xact_fsm (
  input  logic                    clk_48mhz_i,
  input  logic                    rst_ni,
  input  logic                    link_reset_i,
  input  out_ep_pkg::rx_evt_t     rx_evt_i,
  input  logic                    rx_start_i,
  input  logic                    bad_toggle_i,
  input  out_ep_pkg::ep_mask_t    stall_i,
  input  logic                    store_fail_i,
  output out_ep_pkg::xact_state_e state_o,
  output out_ep_pkg::ep_idx_t     cur_ep_o,
  output logic                    newpkt_o,
  output logic                    acked_o,
  output logic                    rollback_o,
  output logic                    flip_o,
  output out_ep_pkg::ep_mask_t    setup_o,
  output logic                    tx_start_o,
  output usb_pid_pkg::usb_pid_e   tx_pid_o
);

  localparam int unsigned TimeoutW = $clog2(`USB_OUT_ACK_TIMEOUT + 1);

  out_ep_pkg::xact_state_e state_q;
  out_ep_pkg::xact_state_e state_d;
  out_ep_pkg::ep_idx_t     cur_ep_q;
  out_ep_pkg::ep_mask_t    setup_q;
  logic [TimeoutW-1:0]     timeout_q;
  logic                    xact_start;
  logic                    is_setup_q;
  logic                    newpkt_q;

  ////////////////////////////////////////
  // Next state and strobes
  ////////////////////////////////////////

  always_comb begin
    state_d    = state_q;
    xact_start = 1'b0;
    tx_start_o = 1'b0;
    tx_pid_o   = usb_pid_pkg::UsbPidAck;
    acked_o    = 1'b0;
    rollback_o = 1'b0;
    flip_o     = 1'b0;

    unique case (state_q)
      out_ep_pkg::XactIdle: begin
        // SETUP only counts on a control endpoint
        if (rx_evt_i.ep_active &&
            (rx_evt_i.out_tok || (rx_evt_i.setup_tok && rx_evt_i.ep_control))) begin
          state_d    = out_ep_pkg::XactWaitData;
          xact_start = 1'b1;
        end
      end

      out_ep_pkg::XactWaitData: begin
        // Host gave up on the data packet
        if (rx_start_i) begin
          state_d = out_ep_pkg::XactInData;
        end else if (timeout_q == '0) begin
          state_d = out_ep_pkg::XactIdle;
        end
      end

      out_ep_pkg::XactInData: begin
        if (bad_toggle_i && !stall_i[cur_ep_q]) begin
          // Repeat of an already accepted packet, ACK again and drop it
          state_d    = out_ep_pkg::XactIdle;
          tx_start_o = 1'b1;
          rollback_o = 1'b1;
        end else if (rx_evt_i.data_bad) begin
          // CRC error or wrong packet kind, no handshake at all
          state_d    = out_ep_pkg::XactIdle;
          rollback_o = 1'b1;
        end else if (rx_evt_i.data_ok) begin
          state_d = out_ep_pkg::XactDataEnd;
        end
      end

      out_ep_pkg::XactDataEnd: begin
        state_d = out_ep_pkg::XactIdle;
        if (is_setup_q) begin
          // SETUP cannot be NAKed, a lost one is resent by the host
          if (store_fail_i) begin
            rollback_o = 1'b1;
          end else begin
            tx_start_o = 1'b1;
            acked_o    = 1'b1;
            flip_o     = 1'b1;
          end
        end else if (stall_i[cur_ep_q]) begin
          tx_start_o = 1'b1;
          tx_pid_o   = usb_pid_pkg::UsbPidStall;
        end else if (store_fail_i) begin
          tx_start_o = 1'b1;
          tx_pid_o   = usb_pid_pkg::UsbPidNak;
          rollback_o = 1'b1;
        end else begin
          tx_start_o = 1'b1;
          acked_o    = 1'b1;
          flip_o     = 1'b1;
        end
      end

      default: state_d = out_ep_pkg::XactIdle;
    endcase
  end

  always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= out_ep_pkg::XactIdle;
    end else if (link_reset_i) begin
      state_q <= out_ep_pkg::XactIdle;
    end else begin
      state_q <= state_d;
    end
  end

  // Reloaded while idle, runs down only while waiting for data
  always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      timeout_q <= TimeoutW'(`USB_OUT_ACK_TIMEOUT);
    end else if (state_q == out_ep_pkg::XactIdle) begin
      timeout_q <= TimeoutW'(`USB_OUT_ACK_TIMEOUT);
    end else if ((state_q == out_ep_pkg::XactWaitData) && (timeout_q != '0)) begin
      timeout_q <= timeout_q - 1'b1;
    end
  end

  ////////////////////////////////////////
  // Transaction context
  ////////////////////////////////////////

  always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      newpkt_q   <= 1'b0;
      cur_ep_q   <= '0;
      is_setup_q <= 1'b0;
    end else begin
      newpkt_q <= xact_start;
      if (xact_start) begin
        cur_ep_q   <= rx_evt_i.ep;
        is_setup_q <= rx_evt_i.setup_tok;
      end
    end
  end

  // Flag tracks the last token kind seen per endpoint
  always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      setup_q <= '0;
    end else if (rx_evt_i.setup_tok && rx_evt_i.ep_active) begin
      setup_q[rx_evt_i.ep] <= 1'b1;
    end else if (rx_evt_i.out_tok && rx_evt_i.ep_active) begin
      setup_q[rx_evt_i.ep] <= 1'b0;
    end
  end

  assign state_o  = state_q;
  assign cur_ep_o = cur_ep_q;
  assign newpkt_o = newpkt_q;
  assign setup_o  = setup_q;

endmodule

// ==== design/usb_out_pe.sv ====
/*
 * Non-buffered full-speed OUT/SETUP protocol engine, no isochronous support
 * The endpoint side must take every put, a full endpoint gets a NAK
 */

module usb_out_pe (
  input  logic                  clk_48mhz_i,
  input  logic                  rst_ni,
  input  logic                  link_reset_i,
  input  logic [6:0]            dev_addr_i,
  input  out_ep_pkg::ep_cfg_t   ep_cfg_i,
  input  out_ep_pkg::tog_wr_t   tog_wr_i,
  input  usb_pid_pkg::rx_pkt_t  rx_pkt_i,
  input  usb_pid_pkg::rx_byte_t rx_byte_i,
  output out_ep_pkg::ep_put_t   put_o,
  output out_ep_pkg::ep_idx_t   cur_ep_o,
  output logic                  newpkt_o,
  output logic                  acked_o,
  output logic                  rollback_o,
  output out_ep_pkg::ep_mask_t  setup_o,
  output out_ep_pkg::ep_mask_t  toggle_o,
  output logic                  tx_start_o,
  output usb_pid_pkg::usb_pid_e tx_pid_o
);

  out_ep_pkg::rx_evt_t     rx_evt;
  out_ep_pkg::xact_state_e state;
  out_ep_pkg::ep_idx_t     cur_ep;
  logic                    bad_toggle;
  logic                    flip;
  logic                    store_fail;

  usb_out_token_decode token_decode_i (
    .rx_pkt_i   (rx_pkt_i),
    .dev_addr_i (dev_addr_i),
    .ep_cfg_i   (ep_cfg_i),
    .rx_evt_o   (rx_evt)
  );

  usb_out_data_toggle data_toggle_i (
    .clk_48mhz_i  (clk_48mhz_i),
    .rst_ni       (rst_ni),
    .link_reset_i (link_reset_i),
    .rx_evt_i     (rx_evt),
    .flip_i       (flip),
    .cur_ep_i     (cur_ep),
    .tog_wr_i     (tog_wr_i),
    .toggle_o     (toggle_o),
    .bad_toggle_o (bad_toggle)
  );

  usb_out_xact_fsm xact_fsm_i (
    .clk_48mhz_i  (clk_48mhz_i),
    .rst_ni       (rst_ni),
    .link_reset_i (link_reset_i),
    .rx_evt_i     (rx_evt),
    .rx_start_i   (rx_pkt_i.pkt_start),
    .bad_toggle_i (bad_toggle),
    .stall_i      (ep_cfg_i.stall),
    .store_fail_i (store_fail),
    .state_o      (state),
    .cur_ep_o     (cur_ep),
    .newpkt_o     (newpkt_o),
    .acked_o      (acked_o),
    .rollback_o   (rollback_o),
    .flip_o       (flip),
    .setup_o      (setup_o),
    .tx_start_o   (tx_start_o),
    .tx_pid_o     (tx_pid_o)
  );

  usb_out_data_path data_path_i (
    .clk_48mhz_i  (clk_48mhz_i),
    .rst_ni       (rst_ni),
    .rx_byte_i    (rx_byte_i),
    .state_i      (state),
    .cur_ep_i     (cur_ep),
    .full_i       (ep_cfg_i.full),
    .put_o        (put_o),
    .store_fail_o (store_fail)
  );

  assign cur_ep_o = cur_ep;

endmodule

// ==== dv/usb_out_pe_tb.sv ====
/*
 * Case-driven testbench, one transaction per line of dv/usb_out_cases.txt
 * Packet framing is ideal and the device address is fixed at 5
 */

`include "usb_out_defines.svh"

module usb_out_pe_tb;

  localparam int Cols     = 15;
  localparam int MaxCases = 40;
  localparam int RespWait = 6;

  logic                  clk_48mhz;
  logic                  rst_n;
  logic                  link_reset;
  logic [6:0]            dev_addr;
  out_ep_pkg::ep_cfg_t   ep_cfg;
  out_ep_pkg::tog_wr_t   tog_wr;
  usb_pid_pkg::rx_pkt_t  rx_pkt;
  usb_pid_pkg::rx_byte_t rx_byte;
  out_ep_pkg::ep_put_t   put;
  out_ep_pkg::ep_idx_t   cur_ep;
  logic                  newpkt;
  logic                  acked;
  logic                  rollback;
  out_ep_pkg::ep_mask_t  setup;
  out_ep_pkg::ep_mask_t  toggle;
  logic                  tx_start;
  usb_pid_pkg::usb_pid_e tx_pid;

  logic [7:0]            case_mem [0:Cols*MaxCases-1];
  logic [7:0]            bytes_q [$];
  out_ep_pkg::ep_put_t   puts_q [$];
  usb_pid_pkg::usb_pid_e tx_pid_seen;
  int                    tx_count;
  int                    acked_count;
  int                    rb_count;
  int                    newpkt_count;
  int                    errors;

  usb_out_pe usb_out_pe_i (
    .clk_48mhz_i  (clk_48mhz),
    .rst_ni       (rst_n),
    .link_reset_i (link_reset),
    .dev_addr_i   (dev_addr),
    .ep_cfg_i     (ep_cfg),
    .tog_wr_i     (tog_wr),
    .rx_pkt_i     (rx_pkt),
    .rx_byte_i    (rx_byte),
    .put_o        (put),
    .cur_ep_o     (cur_ep),
    .newpkt_o     (newpkt),
    .acked_o      (acked),
    .rollback_o   (rollback),
    .setup_o      (setup),
    .toggle_o     (toggle),
    .tx_start_o   (tx_start),
    .tx_pid_o     (tx_pid)
  );

  initial begin
    clk_48mhz = 1'b0;
    forever #10 clk_48mhz = ~clk_48mhz;
  end

  // Outputs settle between edges, so sample on the falling edge
  always @(negedge clk_48mhz) begin
    if (rst_n) begin
      if (tx_start) begin
        tx_count++;
        tx_pid_seen = tx_pid;
      end
      if (acked) acked_count++;
      if (rollback) rb_count++;
      if (newpkt) newpkt_count++;
      if (put.put) puts_q.push_back(put);
    end
  end

  ////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////

  task automatic check_pid(input string name, input usb_pid_pkg::usb_pid_e exp,
                           input usb_pid_pkg::usb_pid_e got);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s expected %s got %s", $time, name, exp.name(), got.name());
      errors++;
    end
  endtask

  task automatic check_mask(input string name, input out_ep_pkg::ep_mask_t exp,
                            input out_ep_pkg::ep_mask_t got);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s expected %b got %b", $time, name, exp, got);
      errors++;
    end
  endtask

  task automatic check_ep(input string name, input out_ep_pkg::ep_idx_t exp,
                          input out_ep_pkg::ep_idx_t got);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s expected %0d got %0d", $time, name, exp, got);
      errors++;
    end
  endtask

  task automatic check_put(input out_ep_pkg::ep_put_t exp, input out_ep_pkg::ep_put_t got);
    if (got !== exp) begin
      $display("Mismatch at %0t: put_o expected offset %0d data %h got offset %0d data %h",
               $time, exp.offset, exp.data, got.offset, got.data);
      errors++;
    end
  endtask

  task automatic check_count(input string name, input int exp, input int got);
    if (got != exp) begin
      $display("Mismatch at %0t: %s expected %0d got %0d", $time, name, exp, got);
      errors++;
    end
  endtask

  ////////////////////////////////////////
  // Bus model
  ////////////////////////////////////////

  // Packet end always comes with a good CRC
  task automatic drive_pkt(input logic start, input logic stop,
                           input usb_pid_pkg::usb_pid_e pid,
                           input logic [6:0] addr, input logic [3:0] endp);
    usb_pid_pkg::rx_pkt_t pkt;
    pkt.pkt_start = start;
    pkt.pkt_end   = stop;
    pkt.pkt_valid = stop;
    pkt.pid.pid   = pid;
    pkt.addr      = addr;
    pkt.endp      = endp;
    @(posedge clk_48mhz);
    rx_pkt <= pkt;
  endtask

  task automatic send_token(input usb_pid_pkg::usb_pid_e pid,
                            input logic [6:0] addr, input logic [3:0] endp);
    drive_pkt(1'b0, 1'b1, pid, addr, endp);
    drive_pkt(1'b0, 1'b0, pid, addr, endp);
  endtask

  // Short gap after the token, one idle cycle after each byte
  task automatic send_data(input usb_pid_pkg::usb_pid_e pid);
    usb_pid_pkg::rx_byte_t b;
    repeat (3) @(posedge clk_48mhz);
    drive_pkt(1'b1, 1'b0, pid, 7'd0, 4'd0);
    drive_pkt(1'b0, 1'b0, pid, 7'd0, 4'd0);
    foreach (bytes_q[i]) begin
      b.put  = 1'b1;
      b.data = bytes_q[i];
      @(posedge clk_48mhz);
      rx_byte <= b;
      @(posedge clk_48mhz);
      rx_byte <= '0;
    end
    drive_pkt(1'b0, 1'b1, pid, 7'd0, 4'd0);
    drive_pkt(1'b0, 1'b0, pid, 7'd0, 4'd0);
  endtask

  // Handshake comes at the packet end or one cycle later
  task automatic wait_response(input logic expect_tx);
    for (int i = 0; i < RespWait; i++) begin
      @(posedge clk_48mhz);
      if (tx_count != 0) break;
    end
    if (expect_tx && (tx_count == 0)) begin
      $display("No handshake from the DUT within %0d cycles of the data packet", RespWait);
      errors++;
    end
    repeat (3) @(posedge clk_48mhz);
  endtask

  function automatic string kind_name(input logic [7:0] kind);
    case (kind)
      8'h00:   return "OUT";
      8'h01:   return "SETUP";
      8'h02:   return "TOGWR";
      8'h03:   return "LINKRST";
      default: return "NODATA";
    endcase
  endfunction

  ////////////////////////////////////////
  // One line of the case file
  ////////////////////////////////////////

  task automatic run_case(input int idx, input int base, inout int failed);
    logic [7:0]           kind;
    logic [3:0]           exp_pid;
    out_ep_pkg::ep_cfg_t  cfg;
    out_ep_pkg::tog_wr_t  wr;
    out_ep_pkg::ep_put_t  exp_put;
    int                   nbytes;
    int                   errors_before;
    errors_before = errors;
    kind          = case_mem[base];
    cfg.enabled   = case_mem[base+4][3:0];
    cfg.control   = case_mem[base+5][3:0];
    cfg.full      = case_mem[base+6][3:0];
    cfg.stall     = case_mem[base+7][3:0];
    nbytes        = int'(case_mem[base+8]);
    exp_pid       = case_mem[base+9][3:0];
    tx_count      = 0;
    acked_count   = 0;
    rb_count      = 0;
    newpkt_count  = 0;
    puts_q.delete();
    bytes_q.delete();
    case (kind)
      8'h02: begin
        // Status and mask share the enable and control columns
        wr.we     = 1'b1;
        wr.status = cfg.enabled;
        wr.mask   = cfg.control;
        @(posedge clk_48mhz);
        tog_wr <= wr;
        @(posedge clk_48mhz);
        tog_wr <= '0;
        repeat (2) @(posedge clk_48mhz);
      end
      8'h03: begin
        @(posedge clk_48mhz);
        link_reset <= 1'b1;
        @(posedge clk_48mhz);
        link_reset <= 1'b0;
        repeat (2) @(posedge clk_48mhz);
      end
      default: begin
        @(posedge clk_48mhz);
        ep_cfg <= cfg;
        for (int i = 0; i < nbytes; i++) bytes_q.push_back(8'($urandom));
        send_token((kind == 8'h01) ? usb_pid_pkg::UsbPidSetup : usb_pid_pkg::UsbPidOut,
                   case_mem[base+1][6:0], case_mem[base+2][3:0]);
        if (kind == 8'h04) begin
          // Let the data wait run out before the next token
          repeat (`USB_OUT_ACK_TIMEOUT + 8) @(posedge clk_48mhz);
        end else begin
          send_data(usb_pid_pkg::usb_pid_e'(case_mem[base+3][3:0]));
          wait_response(exp_pid != 4'h0);
        end
      end
    endcase

    if (exp_pid == 4'h0) begin
      check_count("tx_start_o pulses", 0, tx_count);
    end else if (tx_count != 0) begin
      check_count("tx_start_o pulses", 1, tx_count);
      check_pid("tx_pid_o", usb_pid_pkg::usb_pid_e'(exp_pid), tx_pid_seen);
    end
    check_count("newpkt_o pulses", int'(case_mem[base+10]), newpkt_count);
    // Endpoint of the accepted token stays visible after the transaction
    if (case_mem[base+10] != 8'h00) begin
      check_ep("cur_ep_o", out_ep_pkg::ep_idx_t'(case_mem[base+2]), cur_ep);
    end
    check_count("acked_o pulses", int'(case_mem[base+11]), acked_count);
    check_count("rollback_o pulses", int'(case_mem[base+12]), rb_count);
    check_mask("toggle_o", case_mem[base+13][3:0], toggle);
    check_mask("setup_o", case_mem[base+14][3:0], setup);
    // Accepted data must arrive in order from offset 0
    if (case_mem[base+11] != 8'h00) begin
      check_count("put_o puts", nbytes, puts_q.size());
      for (int i = 0; (i < nbytes) && (i < puts_q.size()); i++) begin
        exp_put.put    = 1'b1;
        exp_put.offset = out_ep_pkg::ep_offset_t'(i);
        exp_put.data   = bytes_q[i];
        check_put(exp_put, puts_q[i]);
      end
    end
    if (errors != errors_before) failed++;
    $display("case %0d %s: %s", idx, kind_name(kind),
             (errors == errors_before) ? "ok" : "failed");
  endtask

  initial begin
    int   base;
    int   cases_run;
    int   cases_failed;
    logic ended;
    rst_n        = 1'b0;
    link_reset   = 1'b0;
    dev_addr     = 7'h05;
    ep_cfg       = '0;
    tog_wr       = '0;
    rx_pkt       = '0;
    rx_byte      = '0;
    errors       = 0;
    cases_run    = 0;
    cases_failed = 0;
    ended        = 1'b0;
    void'($urandom(32'h94e0));
    $readmemh("dv/usb_out_cases.txt", case_mem);

    repeat (4) @(posedge clk_48mhz);
    rst_n <= 1'b1;
    @(posedge clk_48mhz);
    check_mask("toggle_o", '0, toggle);
    check_mask("setup_o", '0, setup);

    for (int c = 0; (c < MaxCases) && !ended; c++) begin
      base = c * Cols;
      if (case_mem[base] === 8'h0f) begin
        ended = 1'b1;
      end else if (^case_mem[base] === 1'bx) begin
        $display("Case file is missing or unreadable at case %0d", c);
        errors++;
        ended = 1'b1;
      end else begin
        run_case(c, base, cases_failed);
        cases_run++;
      end
    end
    if (!ended) begin
      $display("Case file has no end marker within %0d cases", MaxCases);
      errors++;
    end

    $display("%0d cases run, %0d failed, %0d check errors", cases_run, cases_failed, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
+incdir+design
design/usb_pid_pkg.sv
design/out_ep_pkg.sv
design/usb_out_token_decode.sv
design/usb_out_data_toggle.sv
design/usb_out_data_path.sv
design/usb_out_xact_fsm.sv
design/usb_out_pe.sv
dv/usb_out_pe_tb.sv

// ==== Makefile ====
# Verilator build and run of the USB OUT protocol engine testbench
# Any variable below can be overridden on the make command line

VERILATOR  ?= verilator
FILELIST   ?= verilog.f
TOP        ?= usb_out_pe_tb
DUT        ?= usb_out_pe
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --binary --timing -Wno-fatal
LINT_FLAGS ?= --lint-only -Wall --timing
PASS_MSG   ?= TESTS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -Fxq "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(DUT)

clean:
	rm -rf $(BUILD_DIR)

// ==== dv/usb_out_cases.txt ====
// kind addr ep dpid en ctl full stall nbytes, then expected pid newpkt acked rollback toggle setup
// kind 0 OUT 1 SETUP 2 TOGWR (en=status ctl=mask) 3 LINKRST 4 NODATA f end, all values hex
0 05 1 3 f 1 0 0 04 2 1 1 0 2 0  // OUT ep1, ACK flips the toggle
0 05 1 b f 1 0 0 08 2 1 1 0 0 0
0 05 2 3 f 1 0 0 03 2 1 1 0 4 0
0 05 2 b f 1 4 0 03 a 1 0 1 4 0  // ep2 full, NAK and rollback
0 05 3 3 f 1 0 8 02 e 1 0 0 4 0  // ep3 stalled
0 05 2 3 f 1 0 0 02 2 1 0 1 4 0  // Host repeat with old toggle
1 05 0 3 f 1 0 0 08 2 1 1 0 5 1  // SETUP on control ep0
0 05 0 b f 1 0 0 00 2 1 1 0 4 0  // Zero-length status OUT
0 05 1 3 f 1 0 0 05 2 1 1 0 6 0
1 05 1 3 f 1 0 0 04 0 0 0 0 4 2  // SETUP on non-control ep1
2 00 0 0 1 1 0 0 00 0 0 0 0 5 2  // Software sets ep0 toggle
1 05 0 3 f 1 1 0 04 0 1 0 1 4 3  // SETUP to full ep0 is dropped
0 06 2 b f 1 0 0 03 0 0 0 0 4 3  // Other device address
0 05 2 b b 1 0 0 03 0 0 0 0 4 3  // ep2 disabled
0 05 5 3 f 1 0 0 02 0 0 0 0 4 3  // Endpoint 5 not implemented
4 05 3 3 f 1 0 0 00 0 1 0 0 4 3  // Token, then no data packet
0 05 3 3 f 1 0 0 06 2 1 1 0 c 3
2 00 0 0 a 6 0 0 00 0 0 0 0 a 3  // Masked write of bits 1 and 2
3 00 0 0 0 0 0 0 00 0 0 0 0 0 3  // Link reset
0 05 1 3 f 1 0 0 20 2 1 1 0 2 1  // Largest packet
1 05 0 3 f 1 0 0 08 2 1 1 0 3 1
0 05 3 b f 1 0 8 02 e 1 0 0 3 1  // Old toggle on stalled ep3
f 00 0 0 0 0 0 0 00 0 0 0 0 0 0  // End of cases
